// ==== rtl/cordic_pkg.sv ====
package cordic_pkg;

    localparam int DATA_W = 14;
    localparam int FRAC_W = 10;  // Angle and gain fraction bits

    typedef logic signed [DATA_W-1:0] data_t;
    typedef logic signed [DATA_W-1:0] angle_t;  // 1024 = 1 rad

    localparam angle_t ANGLE_PI      = angle_t'(3216);
    localparam angle_t ANGLE_HALF_PI = angle_t'(1608);

    // 1/1.647 with FRAC_W fraction bits
    localparam logic signed [FRAC_W:0] GAIN_K = 11'sd622;

    // atan(2^-i) scaled by 1024, rounded
    function automatic angle_t cordic_atan(input int i);
        case (i)
            0:       return angle_t'(804);
            1:       return angle_t'(475);
            2:       return angle_t'(251);
            3:       return angle_t'(127);
            4:       return angle_t'(64);
            5:       return angle_t'(32);
            6:       return angle_t'(16);
            7:       return angle_t'(8);
            8:       return angle_t'(4);
            9:       return angle_t'(2);
            10:      return angle_t'(1);
            11:      return angle_t'(1);
            default: return '0;  // Below one LSB
        endcase
    endfunction

endpackage

// ==== rtl/cordic_feed.sv ====
`timescale 1ns/1ps

module cordic_feed
    import cordic_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   in_valid_i,
    input  logic   in_vec_mode_i,
    input  data_t  in_x_i,
    input  data_t  in_y_i,
    input  angle_t in_z_i,
    input  logic   adv_i,
    output logic   in_ready_o,
    output logic   valid_o,
    output logic   vec_mode_o,
    output data_t  x_o,
    output data_t  y_o,
    output angle_t z_o
);

    data_t  x_fix;
    data_t  y_fix;
    angle_t z_fix;

    assign in_ready_o = adv_i;  // Whole chain moves together

    // Bring the vector into the right half plane before the iterations
    always_comb begin
        x_fix = in_x_i;
        y_fix = in_y_i;
        z_fix = in_z_i;
        if (in_vec_mode_i) begin
            z_fix = '0;
            if (in_x_i < 0) begin
                x_fix = -in_x_i;
                y_fix = -in_y_i;
                z_fix = (in_y_i >= 0) ? ANGLE_PI : -ANGLE_PI;
            end
        end else if (in_z_i > ANGLE_HALF_PI) begin
            x_fix = -in_x_i;
            y_fix = -in_y_i;
            z_fix = in_z_i - ANGLE_PI;
        end else if (in_z_i < -ANGLE_HALF_PI) begin
            x_fix = -in_x_i;
            y_fix = -in_y_i;
            z_fix = in_z_i + ANGLE_PI;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
        end else if (adv_i) begin
            valid_o <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (adv_i) begin
            vec_mode_o <= in_vec_mode_i;
            x_o        <= x_fix;
            y_o        <= y_fix;
            z_o        <= z_fix;
        end
    end

    a_in_x_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        in_valid_i |-> !$isunknown(in_x_i)
    );

endmodule

// ==== rtl/cordic_stage.sv ====
`timescale 1ns/1ps

module cordic_stage
    import cordic_pkg::*;
#(
    parameter int STAGE_IDX = 0,
    parameter int STAGES    = 12
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   adv_i,
    input  logic   valid_i,
    input  logic   vec_mode_i,
    input  data_t  x_i,
    input  data_t  y_i,
    input  angle_t z_i,
    output logic   valid_o,
    output logic   vec_mode_o,
    output data_t  x_o,
    output data_t  y_o,
    output angle_t z_o
);

    localparam angle_t ATAN = cordic_atan(STAGE_IDX);

    if (STAGE_IDX < 0 || STAGE_IDX >= STAGES) begin : g_bad_idx
        $error("cordic_stage index %0d outside 0..%0d", STAGE_IDX, STAGES - 1);
    end

    data_t x_sh;
    data_t y_sh;
    logic  dir_up;

    assign x_sh = x_i >>> STAGE_IDX;
    assign y_sh = y_i >>> STAGE_IDX;

    // Vectoring drives y to zero, rotation drives z to zero
    assign dir_up = vec_mode_i ? (y_i >= 0) : (z_i < 0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
        end else if (adv_i) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (adv_i) begin
            vec_mode_o <= vec_mode_i;
            x_o        <= dir_up ? x_i + y_sh : x_i - y_sh;
            y_o        <= dir_up ? y_i - x_sh : y_i + x_sh;
            z_o        <= dir_up ? z_i + ATAN : z_i - ATAN;
        end
    end

    a_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(valid_o)
    );

endmodule

// ==== rtl/cordic_drain.sv ====
`timescale 1ns/1ps

module cordic_drain
    import cordic_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   valid_i,
    input  logic   vec_mode_i,
    input  data_t  x_i,
    input  data_t  y_i,
    input  angle_t z_i,
    input  logic   out_ready_i,
    output logic   adv_o,
    output logic   out_valid_o,
    output data_t  out_x_o,
    output data_t  out_y_o,
    output angle_t out_z_o
);

    logic signed [DATA_W+FRAC_W-1:0] x_prod;
    logic signed [DATA_W+FRAC_W-1:0] y_prod;

    // Output slot free or being taken this cycle
    assign adv_o = !out_valid_o || out_ready_i;

    // Gain compensation
    assign x_prod = x_i * GAIN_K;
    assign y_prod = y_i * GAIN_K;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid_o <= 1'b0;
        end else if (adv_o) begin
            out_valid_o <= valid_i;
        end
    end

    // Slice is the floor of the product over 2^FRAC_W
    always_ff @(posedge clk) begin
        if (adv_o) begin
            out_x_o <= x_prod[DATA_W+FRAC_W-1:FRAC_W];
            out_y_o <= vec_mode_i ? '0 : y_prod[DATA_W+FRAC_W-1:FRAC_W];
            out_z_o <= z_i;
        end
    end

    a_out_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid_o && !out_ready_i |=>
            out_valid_o && $stable(out_x_o) && $stable(out_y_o) && $stable(out_z_o)
    );

endmodule

// ==== rtl/cordic_pipe.sv ====
`timescale 1ns/1ps

module cordic_pipe
    import cordic_pkg::*;
#(
    parameter int STAGES = 12
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   in_valid_i,
    output logic   in_ready_o,
    input  logic   in_vec_mode_i,
    input  data_t  in_x_i,
    input  data_t  in_y_i,
    input  angle_t in_z_i,
    output logic   out_valid_o,
    input  logic   out_ready_i,
    output data_t  out_x_o,
    output data_t  out_y_o,
    output angle_t out_z_o
);

    logic adv;

    // Link 0 leaves the feed, link k+1 leaves stage k
    logic   valid_l [STAGES+1];
    logic   mode_l  [STAGES+1];
    data_t  x_l     [STAGES+1];
    data_t  y_l     [STAGES+1];
    angle_t z_l     [STAGES+1];

    cordic_feed u_feed (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid_i    (in_valid_i),
        .in_vec_mode_i (in_vec_mode_i),
        .in_x_i        (in_x_i),
        .in_y_i        (in_y_i),
        .in_z_i        (in_z_i),
        .adv_i         (adv),
        .in_ready_o    (in_ready_o),
        .valid_o       (valid_l[0]),
        .vec_mode_o    (mode_l[0]),
        .x_o           (x_l[0]),
        .y_o           (y_l[0]),
        .z_o           (z_l[0])
    );

    for (genvar k = 0; k < STAGES; k++) begin : g_stage
        cordic_stage #(
            .STAGE_IDX (k),
            .STAGES    (STAGES)
        ) u_stage (
            .clk        (clk),
            .rst_n      (rst_n),
            .adv_i      (adv),
            .valid_i    (valid_l[k]),
            .vec_mode_i (mode_l[k]),
            .x_i        (x_l[k]),
            .y_i        (y_l[k]),
            .z_i        (z_l[k]),
            .valid_o    (valid_l[k+1]),
            .vec_mode_o (mode_l[k+1]),
            .x_o        (x_l[k+1]),
            .y_o        (y_l[k+1]),
            .z_o        (z_l[k+1])
        );
    end

    cordic_drain u_drain (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid_i     (valid_l[STAGES]),
        .vec_mode_i  (mode_l[STAGES]),
        .x_i         (x_l[STAGES]),
        .y_i         (y_l[STAGES]),
        .z_i         (z_l[STAGES]),
        .out_ready_i (out_ready_i),
        .adv_o       (adv),
        .out_valid_o (out_valid_o),
        .out_x_o     (out_x_o),
        .out_y_o     (out_y_o),
        .out_z_o     (out_z_o)
    );

endmodule

// ==== sim/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD     = 10,
    parameter int RST_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset released on a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== sim/tb_cordic_model.svh ====
`ifndef TB_CORDIC_MODEL_SVH
`define TB_CORDIC_MODEL_SVH

import cordic_pkg::*;

int err_cnt;

// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    if (s[0]) begin
        return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
endfunction

// atan(2^-i) in units of 1/1024 rad
function automatic int atan_ref(input int i);
    int atan_tab [12] = '{804, 475, 251, 127, 64, 32, 16, 8, 4, 2, 1, 1};
    if (i < 12) begin
        return atan_tab[i];
    end
    return 0;
endfunction

// Expected output for one item, register widths kept at every step
function automatic void cordic_model(
    input  logic   vec,
    input  int     x_in,
    input  int     y_in,
    input  int     z_in,
    input  int     n_stages,
    output data_t  x_out,
    output data_t  y_out,
    output angle_t z_out
);
    data_t  x;
    data_t  y;
    angle_t z;
    data_t  xs;
    data_t  ys;
    x = data_t'(x_in);
    y = data_t'(y_in);
    z = angle_t'(z_in);
    if (vec) begin
        z = '0;  // Input angle ignored
        if (x_in < 0) begin
            x = data_t'(-x_in);
            y = data_t'(-y_in);
            z = (y_in >= 0) ? ANGLE_PI : -ANGLE_PI;
        end
    end else if (z_in > ANGLE_HALF_PI) begin
        x = data_t'(-x_in);
        y = data_t'(-y_in);
        z = angle_t'(z_in - ANGLE_PI);
    end else if (z_in < -ANGLE_HALF_PI) begin
        x = data_t'(-x_in);
        y = data_t'(-y_in);
        z = angle_t'(z_in + ANGLE_PI);
    end
    for (int i = 0; i < n_stages; i++) begin
        xs = x >>> i;
        ys = y >>> i;
        if (vec ? (y < 0) : (z >= 0)) begin
            x = x - ys;  // Counter-clockwise
            y = y + xs;
            z = angle_t'(z - atan_ref(i));
        end else begin
            x = x + ys;
            y = y - xs;
            z = angle_t'(z + atan_ref(i));
        end
    end
    x_out = data_t'((int'(x) * int'(GAIN_K)) >>> FRAC_W);
    y_out = vec ? data_t'(0) : data_t'((int'(y) * int'(GAIN_K)) >>> FRAC_W);
    z_out = z;
endfunction

task automatic check_value(
    input string              test,
    input string              what,
    input logic signed [31:0] exp_v,
    input logic signed [31:0] act_v
);
    if (exp_v !== act_v) begin
        $display("mismatch %s %s: expected %0d, actual %0d", test, what, exp_v, act_v);
        err_cnt++;
    end
endtask

`endif

// ==== sim/tb_cordic_pipe.sv ====
`timescale 1ns/1ps

module tb_cordic_pipe;

    `include "tb_cordic_model.svh"

    localparam int STAGES  = 12;
    localparam int TIMEOUT = 500;  // Cycles per wait
    localparam int N_ITEMS = 20;

    logic   clk;
    logic   rst_n;
    logic   in_valid;
    logic   in_ready;
    logic   in_vec_mode;
    data_t  in_x;
    data_t  in_y;
    angle_t in_z;
    logic   out_valid;
    logic   out_ready;
    data_t  out_x;
    data_t  out_y;
    angle_t out_z;

    logic [15:0] lfsr_q;
    logic [15:0] ready_q;  // Own LFSR state for the output ready pattern
    data_t       exp_x [$];
    data_t       exp_y [$];
    angle_t      exp_z [$];
    int          test_cnt;
    int          test_fail;

    tb_clk_gen #(
        .PERIOD     (10),
        .RST_CYCLES (10)
    ) u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    cordic_pipe #(
        .STAGES (STAGES)
    ) u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid_i    (in_valid),
        .in_ready_o    (in_ready),
        .in_vec_mode_i (in_vec_mode),
        .in_x_i        (in_x),
        .in_y_i        (in_y),
        .in_z_i        (in_z),
        .out_valid_o   (out_valid),
        .out_ready_i   (out_ready),
        .out_x_o       (out_x),
        .out_y_o       (out_y),
        .out_z_o       (out_z)
    );

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int b = 0; b < n; b++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = (v << 1) | lfsr_q[0];
        end
        return v;
    endfunction

    function automatic logic rand_ready();
        ready_q = lfsr_step(ready_q);
        return ready_q[0];
    endfunction

    function automatic int rand_signed(input int lim);
        return rand_bits(13) % (2 * lim + 1) - lim;
    endfunction

    task automatic wait_reset();
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!rst_n && waited < TIMEOUT);
        if (!rst_n) begin
            $display("timeout: reset was never released");
            err_cnt++;
        end
    endtask

    // Holds the item until accepted, model result queued on acceptance
    task automatic send_item(input logic vec, input int x, input int y, input int z);
        int     waited;
        data_t  ex;
        data_t  ey;
        angle_t ez;
        in_valid    <= 1'b1;
        in_vec_mode <= vec;
        in_x        <= data_t'(x);
        in_y        <= data_t'(y);
        in_z        <= angle_t'(z);
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!in_ready && waited < TIMEOUT);
        if (!in_ready) begin
            $display("timeout: input item was not accepted");
            err_cnt++;
        end else begin
            cordic_model(vec, x, y, z, STAGES, ex, ey, ez);
            exp_x.push_back(ex);
            exp_y.push_back(ey);
            exp_z.push_back(ez);
        end
    endtask

    task automatic send_random(input int kind, input int i);
        logic vec;
        int   x;
        int   y;
        int   z;
        vec = (kind == 3) ? rand_bits(1) : (kind != 2);
        x = rand_signed(3000);
        y = rand_signed(3000);
        z = rand_signed(3216);
        case (kind)
            0: x = rand_bits(12) % 3001;
            1: begin
                x = -1 - rand_bits(12) % 3000;
                y = (i % 2) ? -1 - rand_bits(12) % 3000 : rand_bits(12) % 3001;
            end
            2: begin
                case (i % 3)  // Inside, above and below +-pi/2
                    0: z = rand_bits(12) % 3217 - 1608;
                    1: z = 1609 + rand_bits(11) % 1608;
                    default: z = -1609 - rand_bits(11) % 1608;
                endcase
            end
            default: ;
        endcase
        send_item(vec, x, y, z);
    endtask

    task automatic compare_item(input string name);
        if (exp_x.size() == 0) begin
            $display("unexpected output item in %s", name);
            err_cnt++;
        end else begin
            check_value(name, "x", exp_x.pop_front(), out_x);
            check_value(name, "y", exp_y.pop_front(), out_y);
            check_value(name, "z", exp_z.pop_front(), out_z);
        end
    endtask

    task automatic collect_items(input string name, input int n, input bit stall);
        int     waited;
        bit     held;
        data_t  hx;
        data_t  hy;
        angle_t hz;
        held = 1'b0;
        for (int i = 0; i < n; i++) begin
            waited = 0;
            do begin
                if (stall) out_ready <= rand_ready();
                @(posedge clk);
                waited++;
                check_value(name, "in_ready", !out_valid || out_ready, in_ready);
                if (held && (!out_valid || out_x !== hx || out_y !== hy || out_z !== hz)) begin
                    $display("output of %s changed while stalled", name);
                    err_cnt++;
                end
                held = out_valid && !out_ready;
                hx = out_x;
                hy = out_y;
                hz = out_z;
            end while (!(out_valid && out_ready) && waited < TIMEOUT);
            if (!(out_valid && out_ready)) begin
                $display("timeout: %s got %0d of %0d items", name, i, n);
                err_cnt++;
                return;
            end
            compare_item(name);
        end
        out_ready <= 1'b1;
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("test %s passed", name);
        end else begin
            test_fail++;
            $display("test %s failed with %0d errors", name, err_cnt - errs_before);
        end
    endtask

    task automatic run_stream(input string name, input int kind, input int n, input bit stall);
        int errs0;
        int extra;
        errs0 = err_cnt;
        extra = 0;
        out_ready <= 1'b1;
        fork
            begin
                for (int i = 0; i < n; i++) begin
                    send_random(kind, i);
                end
                in_valid <= 1'b0;
            end
            collect_items(name, n, stall);
        join
        // Pipeline must be empty now
        repeat (STAGES + 4) begin
            @(posedge clk);
            if (out_valid) extra++;
        end
        if (extra != 0 || exp_x.size() != 0) begin
            $display("%s left %0d extra outputs, %0d items missing", name, extra, exp_x.size());
            err_cnt++;
        end
        report_test(name, errs0);
    endtask

    task automatic test_latency();
        int errs0;
        int lat;
        errs0 = err_cnt;
        lat = 0;
        check_value("latency", "out_valid", 0, out_valid);
        check_value("latency", "in_ready", 1, in_ready);
        out_ready <= 1'b1;
        send_item(1'b0, 1000, 500, 300);
        in_valid <= 1'b0;
        do begin
            @(posedge clk);
            lat++;
        end while (!out_valid && lat < TIMEOUT);
        check_value("latency", "cycles", STAGES + 2, lat);
        if (out_valid) compare_item("latency");
        report_test("latency", errs0);
    endtask

    task automatic test_vectoring_pos();
        run_stream("vectoring_pos", 0, N_ITEMS, 1'b0);
    endtask

    task automatic test_vectoring_neg();
        run_stream("vectoring_neg", 1, N_ITEMS, 1'b0);
    endtask

    task automatic test_rotation();
        run_stream("rotation", 2, N_ITEMS, 1'b0);
    endtask

    task automatic test_backpressure();
        run_stream("backpressure", 3, 40, 1'b1);
    endtask

    initial begin
        lfsr_q      = 16'd30213;
        ready_q     = 16'd30213;
        err_cnt     = 0;
        test_cnt    = 0;
        test_fail   = 0;
        in_valid    = 1'b0;
        in_vec_mode = 1'b0;
        in_x        = '0;
        in_y        = '0;
        in_z        = '0;
        out_ready   = 1'b0;
        wait_reset();
        test_latency();
        test_vectoring_pos();
        test_vectoring_neg();
        test_rotation();
        test_backpressure();
        $display("%0d tests run, %0d failed, %0d errors", test_cnt, test_fail, err_cnt);
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== givens_cordic.f ====
+incdir+sim
rtl/cordic_pkg.sv
rtl/cordic_feed.sv
rtl/cordic_stage.sv
rtl/cordic_drain.sv
rtl/cordic_pipe.sv
sim/tb_clk_gen.sv
sim/tb_cordic_pipe.sv

// ==== Bender.yml ====
package:
  name: givens_cordic

sources:
  - files:
      - rtl/cordic_pkg.sv
      - rtl/cordic_feed.sv
      - rtl/cordic_stage.sv
      - rtl/cordic_drain.sv
      - rtl/cordic_pipe.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_clk_gen.sv
      - sim/tb_cordic_pipe.sv
